/* ice_mbus_bridge.f */
+incdir+src
src/ice_host_pkg.sv
src/ice_mbus_pkg.sv
src/mbus_clk_divider.sv
src/command_decoder.sv
src/ack_generator.sv
src/response_fifo.sv
src/mbus_layer_ctrl.sv
src/ice_mbus_bridge.sv
tb/tb_clock_gen.sv
tb/tb_ice_mbus_bridge.sv

/* Makefile */
TOP = tb_ice_mbus_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f ice_mbus_bridge.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

/* tb/tb_ice_mbus_bridge.sv */
`timescale 1ns/100ps
`include "ice_mbus_params.svh"

module tb_ice_mbus_bridge;

	localparam int TIMEOUT = 200;
	localparam logic [`MBUS_DIV_W-1:0] CLK_DIV = `MBUS_DIV_W'(3);
	localparam int N_ENTRIES = 7;

	typedef struct packed {
		logic       is_rx;
		logic [7:0] opcode;
		logic [7:0] length;
		logic [1:0] rx_words;
		logic       ctrl_fail;
		logic [1:0] fail_mask;
		logic [1:0] bcast_mask;
		logic       sends;
		logic [7:0] exp_code;
	} entry_t;

	// rx, opcode, length, rx words, controller fails, fail mask, bcast mask,
	// reaches the controller, response char or upload status
	entry_t entries [N_ENTRIES] = '{
		'{1'b0, 8'h62, 8'd8,  2'd0, 1'b0, 2'b00, 2'b00, 1'b1, `ACK_CHAR},
		'{1'b0, 8'h62, 8'd16, 2'd0, 1'b0, 2'b00, 2'b00, 1'b1, `ACK_CHAR},
		'{1'b0, 8'h62, 8'd8,  2'd0, 1'b1, 2'b00, 2'b00, 1'b1, `NAK_CHAR},
		'{1'b0, 8'h55, 8'd8,  2'd0, 1'b0, 2'b00, 2'b00, 1'b0, `NAK_CHAR},
		'{1'b0, 8'h62, 8'd6,  2'd0, 1'b0, 2'b00, 2'b00, 1'b0, `NAK_CHAR},
		'{1'b1, 8'h00, 8'd0,  2'd1, 1'b0, 2'b00, 2'b01, 1'b0, 8'h01},
		'{1'b1, 8'h00, 8'd0,  2'd2, 1'b0, 2'b10, 2'b00, 1'b0, 8'h02}
	};

	logic                     clk;
	logic                     reset;
	logic [`MBUS_DIV_W-1:0]   mbus_clk_div;
	logic                     mbus_clk;
	ice_host_pkg::host_byte_t host_in;
	logic                     host_valid;
	ice_mbus_pkg::mbus_tx_t   mbus_tx;
	logic                     tx_ack;
	logic                     tx_succ;
	logic                     tx_fail;
	logic                     tx_resp_ack;
	ice_mbus_pkg::mbus_rx_t   mbus_rx;
	logic                     rx_ack;
	logic [7:0]               time_tag;
	logic                     time_tag_incr;
	ice_host_pkg::host_byte_t upload;
	logic                     upload_valid;
	ice_host_pkg::host_byte_t resp;
	logic                     resp_valid;

	int          seed = 32'ha0d1;
	int          req_cycles = 0;
	int          pulses;
	logic [7:0]  frame [$];
	logic [7:0]  exp_bytes [$];
	// Address first, then data words
	logic [31:0] words [4];

	tb_clock_gen clk_gen (.clk(clk), .reset(reset));

	ice_mbus_bridge dut (
		.clk(clk), .reset(reset), .mbus_clk_div(mbus_clk_div), .mbus_clk(mbus_clk),
		.host_in(host_in), .host_valid(host_valid), .mbus_tx(mbus_tx), .tx_ack(tx_ack),
		.tx_succ(tx_succ), .tx_fail(tx_fail), .tx_resp_ack(tx_resp_ack),
		.mbus_rx(mbus_rx), .rx_ack(rx_ack), .time_tag(time_tag),
		.time_tag_incr(time_tag_incr), .upload(upload), .upload_valid(upload_valid),
		.resp(resp), .resp_valid(resp_valid)
	);

	// Counts every cycle with req high
	always @(posedge clk) begin
		if (mbus_tx.req)
			req_cycles <= req_cycles + 1;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else
			stop_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_reset_state();
		int   t;
		int   half;
		int   toggles;
		logic prev;
		t = 0;
		do begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT)
				stop_run("Timeout waiting for reset to be released");
		end while (reset);
		prev = mbus_clk;
		half = 0;
		toggles = 0;
		check_value("mbus_clk", 32'(prev), 32'd0);
		repeat (40) begin
			@(posedge clk);
			check_value("mbus_tx.req", 32'(mbus_tx.req), 32'd0);
			check_value("rx_ack", 32'(rx_ack), 32'd0);
			check_value("upload_valid", 32'(upload_valid), 32'd0);
			check_value("resp_valid", 32'(resp_valid), 32'd0);
			check_value("tx_resp_ack", 32'(tx_resp_ack), 32'd0);
			check_value("time_tag_incr", 32'(time_tag_incr), 32'd0);
			half++;
			if (mbus_clk !== prev) begin
				if (toggles > 0)
					check_value("mbus_clk half period", 32'(half), 32'(CLK_DIV) + 32'd1);
				toggles++;
				half = 0;
				prev = mbus_clk;
			end
		end
		assert (toggles > 2) else
			stop_run("mbus_clk did not toggle after reset");
	endtask

	task automatic send_frame();
		for (int i = 0; i < frame.size(); i++) begin
			@(posedge clk);
			host_in <= '{data: frame[i], last: i == frame.size() - 1};
			host_valid <= 1'b1;
		end
		@(posedge clk);
		host_valid <= 1'b0;
		host_in.last <= 1'b0;
	endtask

	// TX side of the controller model
	task automatic serve_tx(input int n_data, input logic fail_it);
		int t;
		for (int w = 1; w <= n_data; w++) begin
			t = 0;
			do begin
				@(posedge clk);
				t++;
				if (t > TIMEOUT)
					stop_run("Timeout waiting for mbus_tx.req to rise");
			end while (!mbus_tx.req);
			check_value("mbus_tx.addr", mbus_tx.addr, words[0]);
			check_value("mbus_tx.data", mbus_tx.data, words[w]);
			check_value("mbus_tx.pend", 32'(mbus_tx.pend), 32'(w != n_data));
			repeat (2) @(posedge clk);
			tx_ack <= 1'b1;
			t = 0;
			do begin
				@(posedge clk);
				t++;
				if (t > TIMEOUT)
					stop_run("Timeout waiting for mbus_tx.req to fall");
			end while (mbus_tx.req);
			tx_ack <= 1'b0;
		end
		tx_succ <= !fail_it;
		tx_fail <= fail_it;
		t = 0;
		do begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT)
				stop_run("Timeout waiting for tx_resp_ack");
		end while (!tx_resp_ack);
		tx_succ <= 1'b0;
		tx_fail <= 1'b0;
		// The acknowledge is a single-cycle pulse
		@(posedge clk);
		check_value("tx_resp_ack", 32'(tx_resp_ack), 32'd0);
	endtask

	// RX side of the controller model with four-phase req/ack
	task automatic drive_rx(input entry_t e);
		int t;
		int n;
		n = int'(e.rx_words);
		for (int w = 0; w < n; w++) begin
			@(posedge clk);
			mbus_rx <= '{addr: words[0], data: words[w + 1], req: 1'b1,
				pend: w < n - 1, fail: e.fail_mask[w], bcast: e.bcast_mask[w]};
			t = 0;
			do begin
				@(posedge clk);
				t++;
				if (t > TIMEOUT)
					stop_run("Timeout waiting for rx_ack to rise");
			end while (!rx_ack);
			mbus_rx.req <= 1'b0;
			t = 0;
			do begin
				@(posedge clk);
				t++;
				if (t > TIMEOUT)
					stop_run("Timeout waiting for rx_ack to fall");
			end while (rx_ack);
		end
	endtask

	task automatic collect_bytes(input logic from_upload, output int tag_pulses);
		int                       t;
		int                       idx;
		logic                     valid;
		string                    port;
		ice_host_pkg::host_byte_t got;
		t = 0;
		idx = 0;
		tag_pulses = 0;
		port = from_upload ? "upload" : "resp";
		while (idx < exp_bytes.size()) begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT)
				stop_run($sformatf("Timeout waiting for bytes on %s", port));
			if (time_tag_incr)
				tag_pulses++;
			valid = from_upload ? upload_valid : resp_valid;
			got = from_upload ? upload : resp;
			if (valid) begin
				check_value({port, ".data"}, 32'(got.data), 32'(exp_bytes[idx]));
				check_value({port, ".last"}, 32'(got.last), 32'(idx == exp_bytes.size() - 1));
				idx++;
			end
		end
	endtask

	initial begin
		entry_t     e;
		int         req_before;
		logic [7:0] eid;
		logic [7:0] tag;
		host_in = '0;
		host_valid = 1'b0;
		tx_ack = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		mbus_rx = '0;
		time_tag = 8'h00;
		mbus_clk_div = CLK_DIV;
		check_reset_state();
		for (int i = 0; i < N_ENTRIES; i++) begin
			e = entries[i];
			eid = 8'($random(seed));
			tag = 8'($random(seed));
			for (int w = 0; w < 4; w++)
				words[w] = $random(seed);
			frame.delete();
			exp_bytes.delete();
			if (e.is_rx) begin
				time_tag <= tag;
				exp_bytes.push_back(`UPLOAD_FLAG);
				exp_bytes.push_back(tag);
				for (int k = 0; k < 4 * (int'(e.rx_words) + 1); k++)
					exp_bytes.push_back(words[k / 4][31 - 8 * (k % 4) -: 8]);
				exp_bytes.push_back(e.exp_code);
				fork
					drive_rx(e);
					collect_bytes(1'b1, pulses);
				join
				check_value("time_tag_incr pulses", 32'(pulses), 32'd1);
			end else begin
				frame.push_back(e.opcode);
				frame.push_back(eid);
				frame.push_back(e.length);
				// Payload is the address word then the data words, MSB first
				for (int k = 0; k < int'(e.length); k++)
					frame.push_back(words[k / 4][31 - 8 * (k % 4) -: 8]);
				exp_bytes.push_back(e.exp_code);
				exp_bytes.push_back(eid);
				exp_bytes.push_back(8'h00);
				req_before = req_cycles;
				fork
					send_frame();
					if (e.sends)
						serve_tx(int'(e.length) / 4 - 1, e.ctrl_fail);
					collect_bytes(1'b0, pulses);
				join
				if (!e.sends)
					assert (req_cycles == req_before) else
						stop_run("mbus_tx.req was raised for a refused frame");
			end
			repeat (4) @(posedge clk);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* src/ice_mbus_bridge.sv */
`timescale 1ns/100ps
`include "ice_mbus_params.svh"

module ice_mbus_bridge (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`MBUS_DIV_W-1:0]   mbus_clk_div,
	output logic                     mbus_clk,
	input  ice_host_pkg::host_byte_t host_in,
	input  logic                     host_valid,
	output ice_mbus_pkg::mbus_tx_t   mbus_tx,
	input  logic                     tx_ack,
	input  logic                     tx_succ,
	input  logic                     tx_fail,
	output logic                     tx_resp_ack,
	input  ice_mbus_pkg::mbus_rx_t   mbus_rx,
	output logic                     rx_ack,
	input  logic [7:0]               time_tag,
	output logic                     time_tag_incr,
	output ice_host_pkg::host_byte_t upload,
	output logic                     upload_valid,
	output ice_host_pkg::host_byte_t resp,
	output logic                     resp_valid
);

	ice_host_pkg::cmd_header_t header;
	ice_host_pkg::host_byte_t  msg_byte;
	logic                      hdr_done;
	logic                      hdr_bad;
	logic                      buf_pop;
	logic [7:0]                buf_data;
	logic [4:0]                buf_count;
	logic                      gen_ack;
	logic                      gen_nak;
	logic [7:0]                resp_eid;
	logic                      msg_push;

	mbus_clk_divider u_div (
		.clk(clk), .reset(reset), .clk_div(mbus_clk_div), .mbus_clk(mbus_clk)
	);

	command_decoder u_dec (
		.clk(clk), .reset(reset), .host_in(host_in), .host_valid(host_valid),
		.hdr_done(hdr_done), .hdr_bad(hdr_bad), .header(header),
		.buf_pop(buf_pop), .buf_data(buf_data), .buf_count(buf_count)
	);

	mbus_layer_ctrl u_ctrl (
		.clk(clk), .reset(reset), .hdr_done(hdr_done), .hdr_bad(hdr_bad),
		.header(header), .buf_pop(buf_pop), .buf_data(buf_data), .buf_count(buf_count),
		.mbus_tx(mbus_tx), .tx_ack(tx_ack), .tx_succ(tx_succ), .tx_fail(tx_fail),
		.tx_resp_ack(tx_resp_ack), .mbus_rx(mbus_rx), .rx_ack(rx_ack),
		.time_tag(time_tag), .time_tag_incr(time_tag_incr), .upload(upload),
		.upload_valid(upload_valid), .gen_ack(gen_ack), .gen_nak(gen_nak),
		.resp_eid(resp_eid)
	);

	ack_generator u_ackgen (
		.clk(clk), .reset(reset), .gen_ack(gen_ack), .gen_nak(gen_nak),
		.eid(resp_eid), .msg_byte(msg_byte), .msg_push(msg_push)
	);

	response_fifo u_resp (
		.clk(clk), .reset(reset), .msg_byte(msg_byte), .msg_push(msg_push),
		.resp(resp), .resp_valid(resp_valid)
	);

endmodule

/* src/mbus_layer_ctrl.sv */
`timescale 1ns/100ps
`include "ice_mbus_params.svh"

module mbus_layer_ctrl (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      hdr_done,
	input  logic                      hdr_bad,
	input  ice_host_pkg::cmd_header_t header,
	output logic                      buf_pop,
	input  logic [7:0]                buf_data,
	input  logic [4:0]                buf_count,
	output ice_mbus_pkg::mbus_tx_t    mbus_tx,
	input  logic                      tx_ack,
	input  logic                      tx_succ,
	input  logic                      tx_fail,
	output logic                      tx_resp_ack,
	input  ice_mbus_pkg::mbus_rx_t    mbus_rx,
	output logic                      rx_ack,
	input  logic [7:0]                time_tag,
	output logic                      time_tag_incr,
	output ice_host_pkg::host_byte_t  upload,
	output logic                      upload_valid,
	output logic                      gen_ack,
	output logic                      gen_nak,
	output logic [7:0]                resp_eid
);

	ice_mbus_pkg::layer_state_e state, next_state;
	ice_mbus_pkg::rx_status_t   status;
	ice_host_pkg::cmd_header_t  hdr_q;

	logic [1:0]  rx_sync;
	logic        rxreq;
	logic [63:0] data_sr;
	logic [2:0]  byte_cnt;
	logic        first_word;
	logic        cur_pend;
	logic        hdr_pend;
	logic        nak_pend;
	logic [7:0]  nak_eid;
	logic [7:0]  cur_eid;
	logic [5:0]  words_left;
	logic [1:0]  shift_cnt;
	logic [1:0]  gap_cnt;
	logic [31:0] tx_addr;
	logic [31:0] tx_data;
	logic        tx_req;
	logic        tx_pend;
	logic        store;
	logic        shift_sr;
	logic        take_hdr;
	logic        in_tx;

	assign rxreq = rx_sync[1];
	assign mbus_tx = '{addr: tx_addr, data: tx_data, pend: tx_pend, req: tx_req};
	assign resp_eid = (state == ice_mbus_pkg::ST_NAK) ? nak_eid : cur_eid;
	assign in_tx = state inside {ice_mbus_pkg::ST_TX_ADDR, ice_mbus_pkg::ST_TX_DATA,
		ice_mbus_pkg::ST_TX_WAIT, ice_mbus_pkg::ST_TX_REQ, ice_mbus_pkg::ST_TX_END};

	always_comb begin
		next_state    = state;
		store         = 1'b0;
		shift_sr      = 1'b0;
		take_hdr      = 1'b0;
		buf_pop       = 1'b0;
		gen_ack       = 1'b0;
		gen_nak       = 1'b0;
		time_tag_incr = 1'b0;
		upload_valid  = 1'b0;
		upload        = '{data: data_sr[63:56], last: 1'b0};
		case (state)
			ice_mbus_pkg::ST_IDLE: begin
				// RX first, then refused frames, then sends
				if (rxreq && !rx_ack) begin
					store      = 1'b1;
					next_state = ice_mbus_pkg::ST_RX_FLAG;
				end else if (nak_pend) begin
					next_state = ice_mbus_pkg::ST_NAK;
				end else if (hdr_pend && !rx_ack) begin
					take_hdr   = 1'b1;
					next_state = ice_mbus_pkg::ST_TX_ADDR;
				end
			end
			ice_mbus_pkg::ST_RX_FLAG: begin
				upload_valid = 1'b1;
				upload.data  = `UPLOAD_FLAG;
				next_state   = ice_mbus_pkg::ST_RX_TAG;
			end
			ice_mbus_pkg::ST_RX_TAG: begin
				upload_valid  = 1'b1;
				upload.data   = time_tag;
				time_tag_incr = 1'b1;
				next_state    = ice_mbus_pkg::ST_RX_SHIFT;
			end
			ice_mbus_pkg::ST_RX_SHIFT: begin
				upload_valid = 1'b1;
				shift_sr     = 1'b1;
				if (byte_cnt == 3'd0)
					next_state = cur_pend ? ice_mbus_pkg::ST_RX_WAIT : ice_mbus_pkg::ST_RX_STATUS;
			end
			ice_mbus_pkg::ST_RX_WAIT: begin
				// Previous handshake must finish before the next word
				if (rxreq && !rx_ack) begin
					store      = 1'b1;
					next_state = ice_mbus_pkg::ST_RX_SHIFT;
				end
			end
			ice_mbus_pkg::ST_RX_STATUS: begin
				upload_valid = 1'b1;
				upload       = '{data: {6'd0, status.fail, status.bcast}, last: 1'b1};
				next_state   = ice_mbus_pkg::ST_IDLE;
			end
			ice_mbus_pkg::ST_NAK: begin
				gen_nak    = 1'b1;
				next_state = ice_mbus_pkg::ST_GAP;
			end
			ice_mbus_pkg::ST_TX_ADDR, ice_mbus_pkg::ST_TX_DATA: begin
				// Empty buffer with a refusal pending means our bytes were flushed
				if (nak_pend && buf_count == 5'd0) begin
					next_state = ice_mbus_pkg::ST_NAK;
				end else if (buf_count != 5'd0) begin
					buf_pop = 1'b1;
					if (shift_cnt == 2'd3)
						next_state = (state == ice_mbus_pkg::ST_TX_ADDR) ?
							ice_mbus_pkg::ST_TX_DATA : ice_mbus_pkg::ST_TX_WAIT;
				end
			end
			ice_mbus_pkg::ST_TX_WAIT: begin
				if (!tx_ack)
					next_state = ice_mbus_pkg::ST_TX_REQ;
			end
			ice_mbus_pkg::ST_TX_REQ: begin
				if (tx_ack)
					next_state = (words_left == 6'd1) ?
						ice_mbus_pkg::ST_TX_END : ice_mbus_pkg::ST_TX_DATA;
			end
			ice_mbus_pkg::ST_TX_END: begin
				if (tx_fail) begin
					gen_nak    = 1'b1;
					next_state = ice_mbus_pkg::ST_GAP;
				end else if (tx_succ) begin
					gen_ack    = 1'b1;
					next_state = ice_mbus_pkg::ST_GAP;
				end
			end
			ice_mbus_pkg::ST_GAP: begin
				// Ack generator needs three cycles per message
				if (gap_cnt == 2'd2)
					next_state = ice_mbus_pkg::ST_IDLE;
			end
			default: next_state = ice_mbus_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= ice_mbus_pkg::ST_IDLE;
			rx_sync     <= 2'b00;
			rx_ack      <= 1'b0;
			first_word  <= 1'b1;
			status      <= '0;
			hdr_pend    <= 1'b0;
			nak_pend    <= 1'b0;
			shift_cnt   <= 2'd0;
			gap_cnt     <= 2'd0;
			tx_req      <= 1'b0;
			tx_pend     <= 1'b0;
			tx_resp_ack <= 1'b0;
		end else begin
			state       <= next_state;
			rx_sync     <= {rx_sync[0], mbus_rx.req};
			rx_ack      <= store | (rx_ack & rxreq);
			hdr_pend    <= hdr_done | (hdr_pend & ~take_hdr);
			nak_pend    <= hdr_bad | (nak_pend & (state != ice_mbus_pkg::ST_NAK));
			gap_cnt     <= (state == ice_mbus_pkg::ST_GAP) ? gap_cnt + 2'd1 : 2'd0;
			tx_resp_ack <= (state == ice_mbus_pkg::ST_TX_END) && (tx_succ || tx_fail);
			if (next_state != state)
				shift_cnt <= 2'd0;
			else if (buf_pop)
				shift_cnt <= shift_cnt + 2'd1;
			if (store) begin
				first_word   <= 1'b0;
				status.fail  <= status.fail | mbus_rx.fail;
				status.bcast <= status.bcast | mbus_rx.bcast;
			end else if (state == ice_mbus_pkg::ST_RX_STATUS) begin
				first_word <= 1'b1;
				status     <= '0;
			end
			if (state == ice_mbus_pkg::ST_TX_WAIT && !tx_ack) begin
				tx_req  <= 1'b1;
				tx_pend <= words_left != 6'd1;
			end else if (state == ice_mbus_pkg::ST_TX_REQ && tx_ack) begin
				tx_req <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (store) begin
			cur_pend <= mbus_rx.pend;
			data_sr  <= first_word ? {mbus_rx.addr, mbus_rx.data} : {mbus_rx.data, 32'd0};
			byte_cnt <= first_word ? 3'd7 : 3'd3;
		end else if (shift_sr) begin
			data_sr  <= {data_sr[55:0], 8'h00};
			byte_cnt <= byte_cnt - 3'd1;
		end
		if (hdr_done)
			hdr_q <= header;
		if (hdr_bad)
			nak_eid <= header.eid;
		if (take_hdr) begin
			cur_eid    <= hdr_q.eid;
			words_left <= hdr_q.word_count;
		end else if (state == ice_mbus_pkg::ST_TX_REQ && tx_ack) begin
			words_left <= words_left - 6'd1;
		end
		if (buf_pop && state == ice_mbus_pkg::ST_TX_ADDR)
			tx_addr <= {tx_addr[23:0], buf_data};
		if (buf_pop && state == ice_mbus_pkg::ST_TX_DATA)
			tx_data <= {tx_data[23:0], buf_data};
	end

	a_tx_rx_exclusive: assert property (@(posedge clk) disable iff (reset)
		mbus_tx.req |-> !rx_ack);

	a_no_upload_in_tx: assert property (@(posedge clk) disable iff (reset)
		in_tx |-> !upload_valid);

endmodule

/* src/response_fifo.sv */
`timescale 1ns/100ps
`include "ice_mbus_params.svh"

module response_fifo (
	input  logic                     clk,
	input  logic                     reset,
	input  ice_host_pkg::host_byte_t msg_byte,
	input  logic                     msg_push,
	output ice_host_pkg::host_byte_t resp,
	output logic                     resp_valid
);

	localparam int AW = $clog2(`RESP_FIFO_DEPTH);

	ice_host_pkg::host_byte_t mem [`RESP_FIFO_DEPTH];
	logic [AW-1:0]            wr_ptr;
	logic [AW-1:0]            rd_ptr;
	logic [AW:0]              count;
	logic                     pop;

	// The host takes a byte every cycle
	assign pop = count != '0;
	assign resp_valid = pop;
	assign resp = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (msg_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(msg_push) - (AW+1)'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (msg_push)
			mem[wr_ptr] <= msg_byte;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		msg_push |-> count != (AW+1)'(`RESP_FIFO_DEPTH));

endmodule

/* src/ack_generator.sv */
`timescale 1ns/100ps
`include "ice_mbus_params.svh"

module ack_generator (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     gen_ack,
	input  logic                     gen_nak,
	input  logic [7:0]               eid,
	output ice_host_pkg::host_byte_t msg_byte,
	output logic                     msg_push
);

	ice_host_pkg::resp_kind_e kind;
	logic [7:0]               eid_q;
	// 0 idle, then one step per message byte
	logic [1:0]               step;

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= 2'd0;
		end else if (step != 2'd0) begin
			step <= (step == 2'd3) ? 2'd0 : step + 2'd1;
		end else if (gen_ack || gen_nak) begin
			step <= 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (step == 2'd0 && (gen_ack || gen_nak)) begin
			kind  <= gen_nak ? ice_host_pkg::RESP_NAK : ice_host_pkg::RESP_ACK;
			eid_q <= eid;
		end
	end

	always_comb begin
		msg_byte.last = 1'b0;
		case (step)
			2'd1: msg_byte.data = (kind == ice_host_pkg::RESP_NAK) ? `NAK_CHAR : `ACK_CHAR;
			2'd2: msg_byte.data = eid_q;
			default: begin
				msg_byte.data = 8'h00;
				msg_byte.last = 1'b1;
			end
		endcase
	end

	assign msg_push = step != 2'd0;

	a_one_kind: assert property (@(posedge clk) disable iff (reset)
		!(gen_ack && gen_nak));

endmodule

/* src/command_decoder.sv */
`timescale 1ns/100ps
`include "ice_mbus_params.svh"

module command_decoder (
	input  logic                      clk,
	input  logic                      reset,
	input  ice_host_pkg::host_byte_t  host_in,
	input  logic                      host_valid,
	output logic                      hdr_done,
	output logic                      hdr_bad,
	output ice_host_pkg::cmd_header_t header,
	input  logic                      buf_pop,
	output logic [7:0]                buf_data,
	output logic [4:0]                buf_count
);

	localparam int AW = $clog2(`CMD_BUF_DEPTH);

	logic [7:0]    mem [`CMD_BUF_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] rd_ptr_next;
	logic [4:0]    count;
	// 0 opcode, 1 eid, 2 length, 3 payload
	logic [1:0]    pos;
	logic          bad;
	logic          fail_now;
	logic          push;
	logic          full;

	assign full = count == 5'(`CMD_BUF_DEPTH);

	always_comb begin
		fail_now = 1'b0;
		if (host_valid) begin
			case (pos)
				2'd0: fail_now = host_in.data != ice_host_pkg::OP_MBUS_SEND;
				2'd2: fail_now = host_in.data < 8'd8 || host_in.data[1:0] != 2'b00;
				2'd3: fail_now = full;
				default: fail_now = 1'b0;
			endcase
		end
	end

	assign push = host_valid && pos == 2'd3 && !bad && !fail_now;
	assign rd_ptr_next = buf_pop ? rd_ptr + 1'b1 : rd_ptr;
	assign buf_data = mem[rd_ptr];
	assign buf_count = count;

	always_ff @(posedge clk) begin
		if (reset) begin
			pos      <= 2'd0;
			bad      <= 1'b0;
			hdr_done <= 1'b0;
			hdr_bad  <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
		end else begin
			hdr_done <= 1'b0;
			hdr_bad  <= 1'b0;
			rd_ptr   <= rd_ptr_next;
			count    <= count + 5'(push) - 5'(buf_pop);
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (host_valid) begin
				if (pos != 2'd3)
					pos <= pos + 2'd1;
				if (fail_now)
					bad <= 1'b1;
				if (pos == 2'd2 && !fail_now && !bad)
					hdr_done <= 1'b1;
				// Refused frames are resolved and flushed at their last byte
				if (host_in.last) begin
					pos <= 2'd0;
					bad <= 1'b0;
					if (bad || fail_now) begin
						hdr_bad <= 1'b1;
						wr_ptr  <= rd_ptr_next;
						count   <= '0;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= host_in.data;
		if (host_valid) begin
			case (pos)
				2'd0: header.opcode <= ice_host_pkg::host_op_e'(host_in.data);
				2'd1: header.eid <= host_in.data;
				2'd2: header.word_count <= host_in.data[7:2] - 6'd1;
				default: ;
			endcase
		end
	end

	a_pop_not_empty: assert property (@(posedge clk) disable iff (reset)
		buf_pop |-> count != 5'd0);

endmodule

/* src/mbus_clk_divider.sv */
`timescale 1ns/100ps
`include "ice_mbus_params.svh"

module mbus_clk_divider (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`MBUS_DIV_W-1:0] clk_div,
	output logic                   mbus_clk
);

	logic [`MBUS_DIV_W-1:0] div_cnt;

	// Half period of mbus_clk is clk_div+1 cycles of clk
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt  <= '0;
			mbus_clk <= 1'b0;
		end else if (div_cnt == clk_div) begin
			div_cnt  <= '0;
			mbus_clk <= ~mbus_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

/* src/ice_mbus_pkg.sv */
package ice_mbus_pkg;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_RX_FLAG,
		ST_RX_TAG,
		ST_RX_SHIFT,
		ST_RX_WAIT,
		ST_RX_STATUS,
		ST_NAK,
		ST_TX_ADDR,
		ST_TX_DATA,
		ST_TX_WAIT,
		ST_TX_REQ,
		ST_TX_END,
		ST_GAP
	} layer_state_e;

	// Word handed to the layer controller
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        pend;
		logic        req;
	} mbus_tx_t;

	// Word received from the layer controller
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        req;
		logic        pend;
		logic        fail;
		logic        bcast;
	} mbus_rx_t;

	// Accumulated over every word of one upload
	typedef struct packed {
		logic fail;
		logic bcast;
	} rx_status_t;

endpackage

/* src/ice_host_pkg.sv */
package ice_host_pkg;

	// Only MBus sends are supported from the host
	typedef enum logic [7:0] {
		OP_MBUS_SEND = 8'h62
	} host_op_e;

	typedef enum logic {
		RESP_ACK = 1'b0,
		RESP_NAK = 1'b1
	} resp_kind_e;

	// One byte on any host-side stream, last marks the frame end
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} host_byte_t;

	// Word count excludes the address word
	typedef struct packed {
		host_op_e   opcode;
		logic [7:0] eid;
		logic [5:0] word_count;
	} cmd_header_t;

endpackage

/* src/ice_mbus_params.svh */
`ifndef ICE_MBUS_PARAMS_SVH
`define ICE_MBUS_PARAMS_SVH

// Width of the MBus clock divide setting
`define MBUS_DIV_W 22

// Host payload buffer, in bytes
`define CMD_BUF_DEPTH 16

// Response message buffer, in bytes
`define RESP_FIFO_DEPTH 8

// Frame constants seen by the host
`define UPLOAD_FLAG 8'h62
`define ACK_CHAR 8'h79
`define NAK_CHAR 8'h7A

`endif
